/* verilog/rv_core_pkg.sv */
// --------------------------------------------------
// rv_core_pkg: shared widths and encodings for the
// multi-cycle RV32I core
// --------------------------------------------------

package rv_core_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int XLEN          = 32;
    localparam int REG_ADDR_BITS = 5;
    localparam int MEM_ADDR_BITS = 10;
    localparam int PC_STEP       = 4;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // operations seen by execute
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_PASS_IMM,
        ALU_HALT,
        ALU_NOP
    } alu_op_e;

    // controller states, one instruction per lap
    typedef enum logic [2:0] {
        ST_PAUSED,
        ST_FETCH,
        ST_WAIT,
        ST_DECODE,
        ST_EXECUTE
    } ctl_state_e;

endpackage

/* verilog/rv_controller.sv */
// --------------------------------------------------
// rv_controller: FSM stepping fetch, wait, decode and
// execute, with start and halt
// --------------------------------------------------
`timescale 1ns/1ps

module rv_controller (
    input  logic clk,
    input  logic rst_n_i,
    input  logic start_i,
    input  logic halt_i,
    output logic fetch_init_o,
    output logic fetch_req_o,
    output logic ir_load_o,
    output logic decode_en_o,
    output logic exe_en_o,
    output logic paused_o
);

    rv_core_pkg::ctl_state_e state_q;
    rv_core_pkg::ctl_state_e state_d;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= rv_core_pkg::ST_PAUSED;
        end else begin
            state_q <= state_d;
        end
    end

    // one state per cycle, no stalls
    always_comb begin
        state_d = state_q;
        case (state_q)
            rv_core_pkg::ST_PAUSED: begin
                if (start_i) begin
                    state_d = rv_core_pkg::ST_FETCH;
                end
            end
            rv_core_pkg::ST_FETCH:   state_d = rv_core_pkg::ST_WAIT;
            rv_core_pkg::ST_WAIT:    state_d = rv_core_pkg::ST_DECODE;
            rv_core_pkg::ST_DECODE:  state_d = rv_core_pkg::ST_EXECUTE;
            rv_core_pkg::ST_EXECUTE: begin
                // ebreak drops back to the debugger
                state_d = halt_i ? rv_core_pkg::ST_PAUSED : rv_core_pkg::ST_FETCH;
            end
            default: state_d = rv_core_pkg::ST_PAUSED;
        endcase
    end

    // --------------------------------------------------
    // strobes, decoded from state
    // --------------------------------------------------
    assign paused_o     = (state_q == rv_core_pkg::ST_PAUSED);
    assign fetch_init_o = paused_o && start_i;
    assign fetch_req_o  = (state_q == rv_core_pkg::ST_FETCH);
    assign ir_load_o    = (state_q == rv_core_pkg::ST_WAIT);
    assign decode_en_o  = (state_q == rv_core_pkg::ST_DECODE);
    assign exe_en_o     = (state_q == rv_core_pkg::ST_EXECUTE);

endmodule

/* verilog/rv_fetch.sv */
// --------------------------------------------------
// rv_fetch: PC and IR registers, code-memory read
// --------------------------------------------------
`timescale 1ns/1ps

module rv_fetch (
    input  logic                                    clk,
    input  logic                                    rst_n_i,
    input  logic                                    fetch_init_i,
    input  logic [rv_core_pkg::XLEN-1:0]            start_address_i,
    input  logic                                    fetch_req_i,
    input  logic                                    ir_load_i,
    input  logic                                    pc_advance_i,
    input  logic [rv_core_pkg::XLEN-1:0]            mem_read_data_i,
    output logic                                    mem_re_o,
    output logic [rv_core_pkg::MEM_ADDR_BITS-1:0]   mem_addr_o,
    output logic [rv_core_pkg::XLEN-1:0]            pc_o,
    output logic [rv_core_pkg::XLEN-1:0]            ir_o
);

    logic [rv_core_pkg::XLEN-1:0] pc_q;
    logic [rv_core_pkg::XLEN-1:0] ir_q;

    // --------------------------------------------------
    // program counter
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else if (fetch_init_i) begin
            pc_q <= start_address_i;
        end else if (pc_advance_i) begin
            pc_q <= pc_q + rv_core_pkg::XLEN'(rv_core_pkg::PC_STEP);
        end
    end

    // --------------------------------------------------
    // instruction register
    // --------------------------------------------------
    // read data arrives one cycle after the request
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ir_q <= '0;
        end else if (ir_load_i) begin
            ir_q <= mem_read_data_i;
        end
    end

    // word address, byte offset dropped
    assign mem_re_o   = fetch_req_i;
    assign mem_addr_o = pc_q[rv_core_pkg::MEM_ADDR_BITS+1:2];

    assign pc_o = pc_q;
    assign ir_o = ir_q;

endmodule

/* verilog/rv_decode.sv */
// --------------------------------------------------
// rv_decode: registered decode of register fields,
// immediate and ALU operation
// --------------------------------------------------
`timescale 1ns/1ps

module rv_decode (
    input  logic                                    clk,
    input  logic                                    rst_n_i,
    input  logic                                    decode_en_i,
    input  logic [rv_core_pkg::XLEN-1:0]            ir_i,
    output logic [rv_core_pkg::REG_ADDR_BITS-1:0]   rs1_o,
    output logic [rv_core_pkg::REG_ADDR_BITS-1:0]   rs2_o,
    output logic [rv_core_pkg::REG_ADDR_BITS-1:0]   rd_o,
    output logic [rv_core_pkg::XLEN-1:0]            imm_o,
    output rv_core_pkg::alu_op_e                    alu_op_o
);

    localparam logic [rv_core_pkg::XLEN-1:0] EBREAK_INSN = 32'h0010_0073;

    rv_core_pkg::opcode_e                   opcode;
    logic [2:0]                             funct3;
    logic [6:0]                             funct7;
    logic [rv_core_pkg::REG_ADDR_BITS-1:0]  rs2_d;
    logic [rv_core_pkg::XLEN-1:0]           imm_d;
    rv_core_pkg::alu_op_e                   alu_op_d;

    assign opcode = rv_core_pkg::opcode_e'(ir_i[6:0]);
    assign funct3 = ir_i[14:12];
    assign funct7 = ir_i[31:25];

    // execute sums rs1, rs2 and imm for ALU_ADD,
    // so the operand that the instruction lacks is zeroed here
    always_comb begin
        alu_op_d = rv_core_pkg::ALU_NOP;
        rs2_d    = ir_i[24:20];
        imm_d    = {{20{ir_i[31]}}, ir_i[31:20]};
        case (opcode)
            rv_core_pkg::OPC_OP_IMM: begin
                if (funct3 == 3'b000) begin
                    alu_op_d = rv_core_pkg::ALU_ADD;
                    rs2_d    = '0;
                end
            end
            rv_core_pkg::OPC_OP: begin
                imm_d = '0;
                if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
                    alu_op_d = rv_core_pkg::ALU_ADD;
                end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
                    alu_op_d = rv_core_pkg::ALU_SUB;
                end
            end
            rv_core_pkg::OPC_LUI: begin
                alu_op_d = rv_core_pkg::ALU_PASS_IMM;
                imm_d    = {ir_i[31:12], 12'b0};
            end
            rv_core_pkg::OPC_SYSTEM: begin
                if (ir_i == EBREAK_INSN) begin
                    alu_op_d = rv_core_pkg::ALU_HALT;
                end
            end
            default: begin
                // anything else retires as a nop
                alu_op_d = rv_core_pkg::ALU_NOP;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rs1_o    <= '0;
            rs2_o    <= '0;
            rd_o     <= '0;
            imm_o    <= '0;
            alu_op_o <= rv_core_pkg::ALU_NOP;
        end else if (decode_en_i) begin
            rs1_o    <= ir_i[19:15];
            rs2_o    <= rs2_d;
            rd_o     <= ir_i[11:7];
            imm_o    <= imm_d;
            alu_op_o <= alu_op_d;
        end
    end

endmodule

/* verilog/rv_execute.sv */
// --------------------------------------------------
// rv_execute: ALU, write-back request and halt flag
// --------------------------------------------------
`timescale 1ns/1ps

module rv_execute (
    input  logic                                    exe_en_i,
    input  rv_core_pkg::alu_op_e                    alu_op_i,
    input  logic [rv_core_pkg::REG_ADDR_BITS-1:0]   rd_i,
    input  logic [rv_core_pkg::XLEN-1:0]            imm_i,
    input  logic [rv_core_pkg::XLEN-1:0]            rs1_data_i,
    input  logic [rv_core_pkg::XLEN-1:0]            rs2_data_i,
    output logic                                    rd_we_o,
    output logic [rv_core_pkg::REG_ADDR_BITS-1:0]   rd_addr_o,
    output logic [rv_core_pkg::XLEN-1:0]            rd_data_o,
    output logic                                    pc_advance_o,
    output logic                                    halt_o
);

    logic writes_rd;

    // addi and add share one adder, decode zeroes the unused operand
    always_comb begin
        case (alu_op_i)
            rv_core_pkg::ALU_ADD:      rd_data_o = rs1_data_i + rs2_data_i + imm_i;
            rv_core_pkg::ALU_SUB:      rd_data_o = rs1_data_i - rs2_data_i;
            rv_core_pkg::ALU_PASS_IMM: rd_data_o = imm_i;
            default:                   rd_data_o = '0;
        endcase
    end

    assign writes_rd = (alu_op_i == rv_core_pkg::ALU_ADD)
                    || (alu_op_i == rv_core_pkg::ALU_SUB)
                    || (alu_op_i == rv_core_pkg::ALU_PASS_IMM);

    assign rd_we_o      = exe_en_i && writes_rd;
    assign rd_addr_o    = rd_i;
    assign halt_o       = exe_en_i && (alu_op_i == rv_core_pkg::ALU_HALT);
    // pc holds on ebreak so peek shows the halt address
    assign pc_advance_o = exe_en_i && (alu_op_i != rv_core_pkg::ALU_HALT);

endmodule

/* verilog/rv_reg_file.sv */
// --------------------------------------------------
// rv_reg_file: 32 x 32 register file, debugger port
// muxed in while paused
// --------------------------------------------------
`timescale 1ns/1ps

module rv_reg_file (
    input  logic                                    clk,
    input  logic                                    rst_n_i,
    input  logic                                    paused_i,
    input  logic [rv_core_pkg::REG_ADDR_BITS-1:0]   rs1_addr_i,
    input  logic [rv_core_pkg::REG_ADDR_BITS-1:0]   rs2_addr_i,
    input  logic                                    rd_we_i,
    input  logic [rv_core_pkg::REG_ADDR_BITS-1:0]   rd_addr_i,
    input  logic [rv_core_pkg::XLEN-1:0]            rd_data_i,
    input  logic [rv_core_pkg::REG_ADDR_BITS-1:0]   ocd_reg_read_addr_i,
    input  logic                                    ocd_reg_we_i,
    input  logic [rv_core_pkg::REG_ADDR_BITS-1:0]   ocd_reg_write_addr_i,
    input  logic [rv_core_pkg::XLEN-1:0]            ocd_reg_write_data_i,
    output logic [rv_core_pkg::XLEN-1:0]            rs1_data_o,
    output logic [rv_core_pkg::XLEN-1:0]            rs2_data_o
);

    // x0 has no storage
    logic [rv_core_pkg::XLEN-1:0]           regs [1:31];

    logic                                   wr_en;
    logic [rv_core_pkg::REG_ADDR_BITS-1:0]  wr_addr;
    logic [rv_core_pkg::XLEN-1:0]           wr_data;
    logic [rv_core_pkg::REG_ADDR_BITS-1:0]  rd2_addr;

    // --------------------------------------------------
    // debugger owns write port and read port 2 while paused
    // --------------------------------------------------
    assign wr_en    = paused_i ? ocd_reg_we_i         : rd_we_i;
    assign wr_addr  = paused_i ? ocd_reg_write_addr_i : rd_addr_i;
    assign wr_data  = paused_i ? ocd_reg_write_data_i : rd_data_i;
    assign rd2_addr = paused_i ? ocd_reg_read_addr_i  : rs2_addr_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    function automatic logic [rv_core_pkg::XLEN-1:0] read_reg(
        input logic [rv_core_pkg::REG_ADDR_BITS-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end
        return regs[addr];
    endfunction

    // combinational reads
    always_comb begin
        rs1_data_o = read_reg(rs1_addr_i);
        rs2_data_o = read_reg(rd2_addr);
    end

endmodule

/* verilog/rv_core_top.sv */
// --------------------------------------------------
// rv_core_top: multi-cycle RV32I core, wires controller,
// fetch, decode, execute and register file
// --------------------------------------------------
`timescale 1ns/1ps

module rv_core_top (
    input  logic                                    clk,
    input  logic                                    rst_n_i,
    input  logic                                    start_i,
    input  logic [rv_core_pkg::XLEN-1:0]            start_address_i,
    output logic                                    mem_re_o,
    output logic [rv_core_pkg::MEM_ADDR_BITS-1:0]   mem_addr_o,
    input  logic [rv_core_pkg::XLEN-1:0]            mem_read_data_i,
    input  logic [rv_core_pkg::REG_ADDR_BITS-1:0]   ocd_reg_read_addr_i,
    input  logic                                    ocd_reg_we_i,
    input  logic [rv_core_pkg::REG_ADDR_BITS-1:0]   ocd_reg_write_addr_i,
    input  logic [rv_core_pkg::XLEN-1:0]            ocd_reg_write_data_i,
    output logic [rv_core_pkg::XLEN-1:0]            ocd_reg_data_o,
    output logic                                    processor_paused_o,
    output logic [rv_core_pkg::XLEN-1:0]            peek_pc_o,
    output logic [rv_core_pkg::XLEN-1:0]            peek_ir_o
);

    // --------------------------------------------------
    // internal wires
    // --------------------------------------------------
    logic                                   fetch_init;
    logic                                   fetch_req;
    logic                                   ir_load;
    logic                                   decode_en;
    logic                                   exe_en;
    logic                                   paused;
    logic                                   halt;
    logic                                   pc_advance;
    logic [rv_core_pkg::XLEN-1:0]           pc;
    logic [rv_core_pkg::XLEN-1:0]           ir;
    logic [rv_core_pkg::REG_ADDR_BITS-1:0]  rs1;
    logic [rv_core_pkg::REG_ADDR_BITS-1:0]  rs2;
    logic [rv_core_pkg::REG_ADDR_BITS-1:0]  rd;
    logic [rv_core_pkg::XLEN-1:0]           imm;
    rv_core_pkg::alu_op_e                   alu_op;
    logic [rv_core_pkg::XLEN-1:0]           rs1_data;
    logic [rv_core_pkg::XLEN-1:0]           rs2_data;
    logic                                   rd_we;
    logic [rv_core_pkg::REG_ADDR_BITS-1:0]  rd_addr;
    logic [rv_core_pkg::XLEN-1:0]           rd_data;

    // second read port doubles as the debugger read while paused
    assign ocd_reg_data_o     = rs2_data;
    assign processor_paused_o = paused;
    assign peek_pc_o          = pc;
    assign peek_ir_o          = ir;

    rv_controller rv_controller_inst (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .start_i      (start_i),
        .halt_i       (halt),
        .fetch_init_o (fetch_init),
        .fetch_req_o  (fetch_req),
        .ir_load_o    (ir_load),
        .decode_en_o  (decode_en),
        .exe_en_o     (exe_en),
        .paused_o     (paused)
    );

    rv_fetch rv_fetch_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .fetch_init_i    (fetch_init),
        .start_address_i (start_address_i),
        .fetch_req_i     (fetch_req),
        .ir_load_i       (ir_load),
        .pc_advance_i    (pc_advance),
        .mem_read_data_i (mem_read_data_i),
        .mem_re_o        (mem_re_o),
        .mem_addr_o      (mem_addr_o),
        .pc_o            (pc),
        .ir_o            (ir)
    );

    rv_decode rv_decode_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .decode_en_i (decode_en),
        .ir_i        (ir),
        .rs1_o       (rs1),
        .rs2_o       (rs2),
        .rd_o        (rd),
        .imm_o       (imm),
        .alu_op_o    (alu_op)
    );

    rv_execute rv_execute_inst (
        .exe_en_i     (exe_en),
        .alu_op_i     (alu_op),
        .rd_i         (rd),
        .imm_i        (imm),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rd_we_o      (rd_we),
        .rd_addr_o    (rd_addr),
        .rd_data_o    (rd_data),
        .pc_advance_o (pc_advance),
        .halt_o       (halt)
    );

    rv_reg_file rv_reg_file_inst (
        .clk                  (clk),
        .rst_n_i              (rst_n_i),
        .paused_i             (paused),
        .rs1_addr_i           (rs1),
        .rs2_addr_i           (rs2),
        .rd_we_i              (rd_we),
        .rd_addr_i            (rd_addr),
        .rd_data_i            (rd_data),
        .ocd_reg_read_addr_i  (ocd_reg_read_addr_i),
        .ocd_reg_we_i         (ocd_reg_we_i),
        .ocd_reg_write_addr_i (ocd_reg_write_addr_i),
        .ocd_reg_write_data_i (ocd_reg_write_data_i),
        .rs1_data_o           (rs1_data),
        .rs2_data_o           (rs2_data)
    );

endmodule

/* test/rv_core_chk.sv */
// --------------------------------------------------
// rv_core_chk: protocol assertions on the core strobes
// --------------------------------------------------
`timescale 1ns/1ps

module rv_core_chk (
    input logic clk,
    input logic rst_n_i,
    input logic mem_re_i,
    input logic paused_i
);

    int unsigned error_count = 0;

    // no fetch while the debugger owns the core
    a_no_fetch_when_paused: assert property (
        @(posedge clk) disable iff (!rst_n_i) !(mem_re_i && paused_i)
    ) else begin
        $error("mem_re_o high while processor_paused_o is high");
        error_count++;
    end

    // read pulses are single cycle
    a_single_cycle_read: assert property (
        @(posedge clk) disable iff (!rst_n_i) mem_re_i |=> !mem_re_i
    ) else begin
        $error("mem_re_o high on two consecutive cycles");
        error_count++;
    end

    a_paused_after_reset: assert property (
        @(posedge clk) $rose(rst_n_i) |-> paused_i
    ) else begin
        $error("processor_paused_o low right after reset release");
        error_count++;
    end

endmodule

bind rv_core_top rv_core_chk rv_core_chk_inst (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .mem_re_i (mem_re_o),
    .paused_i (processor_paused_o)
);

/* test/tb_rv_core.sv */
// --------------------------------------------------
// tb_rv_core: directed tests of the RV32I core with a
// code-memory model and a reference register array
// --------------------------------------------------
`timescale 1ns/1ps

module tb_rv_core;

    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;
    localparam int          WAIT_LIMIT  = 400;

    logic        clk;
    logic        rst_n_i;
    logic        start_i;
    logic [31:0] start_address_i;
    logic        mem_re_o;
    logic [9:0]  mem_addr_o;
    logic [31:0] mem_read_data_i;
    logic [4:0]  ocd_reg_read_addr_i;
    logic        ocd_reg_we_i;
    logic [4:0]  ocd_reg_write_addr_i;
    logic [31:0] ocd_reg_write_data_i;
    logic [31:0] ocd_reg_data_o;
    logic        processor_paused_o;
    logic [31:0] peek_pc_o;
    logic [31:0] peek_ir_o;

    integer      seed;
    logic [31:0] code_mem [0:1023];
    logic [31:0] ref_regs [0:31];
    logic [9:0]  fetch_log [$];

    rv_core_top rv_core_top_inst (
        .clk                  (clk),
        .rst_n_i              (rst_n_i),
        .start_i              (start_i),
        .start_address_i      (start_address_i),
        .mem_re_o             (mem_re_o),
        .mem_addr_o           (mem_addr_o),
        .mem_read_data_i      (mem_read_data_i),
        .ocd_reg_read_addr_i  (ocd_reg_read_addr_i),
        .ocd_reg_we_i         (ocd_reg_we_i),
        .ocd_reg_write_addr_i (ocd_reg_write_addr_i),
        .ocd_reg_write_data_i (ocd_reg_write_data_i),
        .ocd_reg_data_o       (ocd_reg_data_o),
        .processor_paused_o   (processor_paused_o),
        .peek_pc_o            (peek_pc_o),
        .peek_ir_o            (peek_ir_o)
    );

    always #10 clk = ~clk;

    // --------------------------------------------------
    // code memory, data one cycle after the read pulse
    // --------------------------------------------------
    always @(posedge clk) begin
        logic [9:0] read_addr;
        if (mem_re_o) begin
            read_addr = mem_addr_o;
            fetch_log.push_back(read_addr);
            #2;
            mem_read_data_i = code_mem[read_addr];
        end
    end

    function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] funct3, input logic [4:0] rd,
                                               input logic [6:0] opcode);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] rtype_word(input logic [6:0] funct7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [4:0] rd);
        return {funct7, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
            abort_run();
        end
    endtask

    // inputs change 2 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic debug_write(input logic [4:0] addr, input logic [31:0] data);
        step();
        ocd_reg_we_i         = 1'b1;
        ocd_reg_write_addr_i = addr;
        ocd_reg_write_data_i = data;
        step();
        ocd_reg_we_i = 1'b0;
    endtask

    task automatic debug_read(input logic [4:0] addr, output logic [31:0] data);
        step();
        ocd_reg_read_addr_i = addr;
        @(negedge clk);
        data = ocd_reg_data_o;
    endtask

    task automatic compare_regs();
        logic [31:0] data;
        for (int r = 0; r < 32; r++) begin
            debug_read(r[4:0], data);
            check_value($sformatf("ocd_reg_data_o x%0d", r), data, ref_regs[r]);
        end
    endtask

    // random addi, add, sub and lui, closed by ebreak
    task automatic build_random_program(input logic [31:0] base, input int count);
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        logic [31:0] word;
        logic [31:0] result;
        for (int k = 0; k < count; k++) begin
            kind = $unsigned($random(seed)) % 4;
            rd   = $random(seed);
            rs1  = $random(seed);
            rs2  = $random(seed);
            imm  = $random(seed);
            case (kind)
                0: begin
                    word   = itype_word(imm[11:0], rs1, 3'b000, rd, 7'b0010011);
                    result = ref_regs[rs1] + {{20{imm[11]}}, imm[11:0]};
                end
                1: begin
                    word   = rtype_word(7'b0000000, rs2, rs1, rd);
                    result = ref_regs[rs1] + ref_regs[rs2];
                end
                2: begin
                    word   = rtype_word(7'b0100000, rs2, rs1, rd);
                    result = ref_regs[rs1] - ref_regs[rs2];
                end
                default: begin
                    word   = {imm[31:12], rd, 7'b0110111};
                    result = {imm[31:12], 12'b0};
                end
            endcase
            code_mem[(base >> 2) + k] = word;
            if (rd != 5'd0) begin
                ref_regs[rd] = result;
            end
        end
        code_mem[(base >> 2) + count] = EBREAK_WORD;
    endtask

    // count includes the closing ebreak
    task automatic run_from(input logic [31:0] base, input int count, input bit poke);
        int          cycles;
        logic [31:0] expect_addr;
        fetch_log.delete();
        step();
        start_i         = 1'b1;
        start_address_i = base;
        step();
        start_i = 1'b0;
        assert (!processor_paused_o) else begin
            $display("core stayed paused after the start pulse");
            abort_run();
        end
        cycles = 0;
        while (!processor_paused_o) begin
            @(negedge clk);
            if (!processor_paused_o) begin
                cycles++;
                if (cycles > WAIT_LIMIT) begin
                    $display("timeout waiting for the core to pause");
                    abort_run();
                end
                step();
                // debugger writes while running must be ignored
                ocd_reg_we_i         = poke && (cycles < 8);
                ocd_reg_write_addr_i = 5'd20 + cycles[4:0];
                ocd_reg_write_data_i = $random(seed);
            end
        end
        check_value("mem_re_o pulse count", fetch_log.size(), count);
        for (int k = 0; k < count; k++) begin
            expect_addr = base + 4 * k;
            check_value("mem_addr_o", {22'd0, fetch_log[k]}, {22'd0, expect_addr[11:2]});
        end
        check_value("peek_pc_o", peek_pc_o, base + 4 * (count - 1));
        check_value("peek_ir_o", peek_ir_o, EBREAK_WORD);
        compare_regs();
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic test_reset_state();
        logic [31:0] data;
        int          probe [4] = '{0, 1, 15, 31};
        for (int c = 0; c < 6; c++) begin
            @(negedge clk);
            check_value("processor_paused_o", processor_paused_o, 1);
            check_value("mem_re_o", mem_re_o, 0);
        end
        check_value("peek_pc_o", peek_pc_o, 0);
        check_value("peek_ir_o", peek_ir_o, 0);
        for (int p = 0; p < 4; p++) begin
            debug_read(probe[p][4:0], data);
            check_value($sformatf("ocd_reg_data_o x%0d", probe[p]), data, 0);
        end
    endtask

    task automatic test_debug_access();
        logic [31:0] data;
        for (int r = 1; r < 32; r++) begin
            data = $random(seed);
            debug_write(r[4:0], data);
            ref_regs[r] = data;
        end
        // x0 stays zero
        debug_write(5'd0, 32'hffff_ffff);
        compare_regs();
    endtask

    task automatic test_nop_isolation();
        logic [31:0] imm;
        logic [31:0] filler;
        imm          = $random(seed);
        filler       = $random(seed);
        code_mem[64] = {filler[31:7], 7'b0001011};
        code_mem[65] = itype_word(imm[11:0], 5'd0, 3'b000, 5'd9, 7'b0010011);
        ref_regs[9]  = {{20{imm[11]}}, imm[11:0]};
        // slti and a load fall outside the kept set
        code_mem[66] = itype_word(imm[11:0], 5'd9, 3'b010, 5'd9, 7'b0010011);
        code_mem[67] = itype_word(imm[11:0], 5'd9, 3'b010, 5'd10, 7'b0000011);
        code_mem[68] = rtype_word(7'b0000000, 5'd9, 5'd9, 5'd11);
        ref_regs[11] = ref_regs[9] + ref_regs[9];
        code_mem[69] = EBREAK_WORD;
        run_from(32'h0000_0100, 6, 1'b1);
    endtask

    initial begin
        seed                 = 32'h4e83_7543;
        clk                  = 1'b0;
        rst_n_i              = 1'b0;
        start_i              = 1'b0;
        start_address_i      = '0;
        mem_read_data_i      = '0;
        ocd_reg_read_addr_i  = '0;
        ocd_reg_we_i         = 1'b0;
        ocd_reg_write_addr_i = '0;
        ocd_reg_write_data_i = '0;
        // custom-0 opcode fill, each word tagged with its address
        for (int i = 0; i < 1024; i++) begin
            code_mem[i] = {15'd0, i[9:0], 7'b0001011};
        end
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        repeat (8) @(posedge clk);
        #2;
        rst_n_i = 1'b1;

        test_reset_state();
        test_debug_access();
        build_random_program(32'h0000_0000, 12);
        run_from(32'h0000_0000, 13, 1'b0);
        build_random_program(32'h0000_0a40, 6);
        run_from(32'h0000_0a40, 7, 1'b0);
        test_nop_isolation();
        step();

        if (rv_core_top_inst.rv_core_chk_inst.error_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("bound protocol assertions reported errors");
            abort_run();
        end
    end

endmodule

/* files.f */
verilog/rv_core_pkg.sv
verilog/rv_controller.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_reg_file.sv
verilog/rv_core_top.sv
test/rv_core_chk.sv
test/tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - verilog/rv_core_pkg.sv
  - verilog/rv_controller.sv
  - verilog/rv_fetch.sv
  - verilog/rv_decode.sv
  - verilog/rv_execute.sv
  - verilog/rv_reg_file.sv
  - verilog/rv_core_top.sv
  - target: test
    files:
      - test/rv_core_chk.sv
      - test/tb_rv_core.sv
